//--- flist.f
hw/fetch_pkg.sv
hw/address_generation.sv
hw/prefetch_queue.sv
hw/instr_decode.sv
hw/branch_execute.sv
hw/retire_result.sv
hw/fetch_top.sv
bench/tb_imem.sv
bench/tb_fetch_top.sv

//--- bench/tb_fetch_top.sv
// ====================
// Directed tests for the fetch front end
// Reference interpreter walks the memory image and checks every retirement
// ====================
`timescale 1ns/1ps

module tb_fetch_top;
   import fetch_pkg::*;

   // Retirements collected per test
   localparam int N_FIRST   = 20;
   localparam int N_STRAIGHT = 16;
   localparam int N_NEAR    = 30;
   localparam int N_FAR     = 10;
   localparam int N_ILLEGAL = 12;
   localparam int N_RANDOM  = 60;
   localparam int WATCHDOG_CYCLES =
      (N_FIRST + N_STRAIGHT + N_NEAR + N_FAR + N_ILLEGAL + N_RANDOM) * 40;

   logic        clk;
   logic        rst;
   logic        imem_ready;
   logic        imem_rvalid;
   line_t       imem_rdata;
   logic [2:0]  reg_sel;
   logic        imem_valid;
   addr_t       imem_address;
   logic        retire;
   retire_t     retire_info;
   logic [15:0] reg_value;

   // Interpreter state
   offset_t     ref_ip;
   seg_t        ref_cs;
   logic [15:0] ref_regs [8];
   logic [11:0] wp;
   int          errors;
   int          checks;

   fetch_top i_dut (
      .clk          (clk),
      .rst          (rst),
      .imem_ready   (imem_ready),
      .imem_rvalid  (imem_rvalid),
      .imem_rdata   (imem_rdata),
      .reg_sel      (reg_sel),
      .imem_valid   (imem_valid),
      .imem_address (imem_address),
      .retire       (retire),
      .retire_info  (retire_info),
      .reg_value    (reg_value)
   );

   tb_imem i_imem (
      .clk          (clk),
      .rst          (rst),
      .imem_valid   (imem_valid),
      .imem_address (imem_address),
      .imem_ready   (imem_ready),
      .imem_rvalid  (imem_rvalid),
      .imem_rdata   (imem_rdata)
   );

   always #5 clk = ~clk;

   task automatic compare_field(input string name, input logic [31:0] got,
                                input logic [31:0] want);
      checks++;
      if (got !== want) begin
         $display("Mismatch %s: got %h expected %h at %0t", name, got, want, $time);
         errors++;
      end
   endtask

   // Byte k of the instruction at the interpreter's IP
   function automatic logic [7:0] code_at(input int k);
      addr_t lin;
      lin = {ref_cs, 16'h0} + ref_ip + addr_t'(k);
      return i_imem.image[lin[11:0]];
   endfunction

   task automatic code_byte(input logic [7:0] b);
      i_imem.image[wp] = b;
      wp = wp + 12'd1;
   endtask

   task automatic origin(input offset_t off);
      wp = off[11:0];
   endtask

   task automatic nop_instr();
      code_byte(8'h90);
   endtask

   task automatic mov_imm(input logic [2:0] r, input logic [15:0] v);
      code_byte({5'b10111, r});
      code_byte(v[7:0]);
      code_byte(v[15:8]);
   endtask

   task automatic short_jmp(input logic [7:0] d);
      code_byte(8'hEB);
      code_byte(d);
   endtask

   task automatic near_jmp(input logic [15:0] d);
      code_byte(8'hE9);
      code_byte(d[7:0]);
      code_byte(d[15:8]);
   endtask

   task automatic far_jmp(input logic [15:0] off, input logic [15:0] cs);
      code_byte(8'hEA);
      code_byte(off[7:0]);
      code_byte(off[15:8]);
      code_byte(cs[7:0]);
      code_byte(cs[15:8]);
   endtask

   task automatic self_loop();
      short_jmp(8'hFE);
   endtask

   // Hold reset, fill memory, point the writer at the reset vector
   task automatic begin_program();
      @(negedge clk);
      rst = 1'b1;
      for (int a = 0; a < 4096; a++)
         i_imem.image[a] = 8'((a * 157) ^ (a >> 4));
      wp = 12'hFF0;
   endtask

   task automatic release_reset();
      repeat (8) @(negedge clk);
      compare_field("imem_valid", 32'(imem_valid), 32'h0);
      compare_field("retire", 32'(retire), 32'h0);
      rst    = 1'b0;
      ref_ip = 32'h0000_FFF0;
      ref_cs = 16'hF000;
      for (int r = 0; r < 8; r++)
         ref_regs[r] = 16'h0;
   endtask

   task automatic check_retire();
      logic [7:0]  op;
      logic [7:0]  b1;
      logic [7:0]  b2;
      logic [7:0]  b3;
      logic [7:0]  b4;
      logic [2:0]  len;
      instr_kind_e kind;
      logic [15:0] value;
      offset_t     next_ip;
      seg_t        next_cs;
      op      = code_at(0);
      b1      = code_at(1);
      b2      = code_at(2);
      b3      = code_at(3);
      b4      = code_at(4);
      len     = 3'd1;
      kind    = K_ILLEGAL;
      value   = 16'h0;
      next_cs = ref_cs;
      if (op == 8'h90) begin
         kind = K_NOP;
      end else if (op >= 8'hB8 && op <= 8'hBF) begin
         kind  = K_MOV;
         len   = 3'd3;
         value = {b2, b1};
      end else if (op == 8'hEB) begin
         kind = K_JMP_NEAR;
         len  = 3'd2;
      end else if (op == 8'hE9) begin
         kind = K_JMP_NEAR;
         len  = 3'd3;
      end else if (op == 8'hEA) begin
         kind = K_JMP_FAR;
         len  = 3'd5;
      end
      next_ip = ref_ip + offset_t'(len);
      // Displacement counts from the end of the jump
      if (op == 8'hEB)
         next_ip = next_ip + {{24{b1[7]}}, b1};
      if (op == 8'hE9)
         next_ip = next_ip + {{16{b2[7]}}, b2, b1};
      if (op == 8'hEA) begin
         next_ip = {16'h0, b2, b1};
         next_cs = {b4, b3};
      end
      if (kind == K_MOV)
         ref_regs[op[2:0]] = value;
      compare_field("retire_info.cs", 32'(retire_info.cs), 32'(ref_cs));
      compare_field("retire_info.offset", retire_info.offset, ref_ip);
      compare_field("retire_info.opcode", 32'(retire_info.opcode), 32'(op));
      compare_field("retire_info.len", 32'(retire_info.len), 32'(len));
      compare_field("retire_info.kind", 32'(retire_info.kind), 32'(kind));
      // Register number sits in the low opcode bits
      if (kind == K_MOV)
         compare_field("retire_info.dest", 32'(retire_info.dest), 32'(op[2:0]));
      compare_field("retire_info.wr_value", 32'(retire_info.wr_value), 32'(value));
      ref_ip = next_ip;
      ref_cs = next_cs;
   endtask

   task automatic collect_retires(input int n);
      int got;
      got = 0;
      while (got < n) begin
         @(negedge clk);
         if (retire) begin
            check_retire();
            got++;
         end
      end
   endtask

   task automatic check_registers();
      for (int r = 0; r < 8; r++) begin
         @(negedge clk);
         reg_sel = 3'(r);
         @(negedge clk);
         compare_field($sformatf("reg_value[%0d]", r), 32'(reg_value), 32'(ref_regs[r]));
      end
   endtask

   // Sampled just after the memory model drives ready
   task automatic watch_requests(input int n);
      addr_t want;
      addr_t held;
      logic  stalled;
      int    seen;
      want    = 32'hF000_FFF0;
      held    = '0;
      stalled = 1'b0;
      seen    = 0;
      while (seen < n) begin
         @(negedge clk);
         #1;
         if (stalled && imem_valid)
            compare_field("imem_address", imem_address, held);
         if (imem_valid && imem_ready) begin
            compare_field("imem_address", imem_address, want);
            want = want + 32'd16;
            seen++;
         end
         stalled = imem_valid && !imem_ready;
         held    = imem_address;
      end
   endtask

   task automatic first_requests();
      begin_program();
      repeat (48) nop_instr();
      self_loop();
      release_reset();
      fork
         watch_requests(3);
         collect_retires(N_FIRST);
      join
   endtask

   // Crosses a line boundary from the reset vector with one MOV split across it
   task automatic straight_line();
      begin_program();
      for (int r = 0; r < 8; r++) begin
         mov_imm(3'(r), 16'(16'h1111 * (r + 1)) ^ 16'h0F0F);
         if (r % 2 == 1)
            nop_instr();
      end
      self_loop();
      release_reset();
      collect_retires(N_STRAIGHT);
      check_registers();
   endtask

   task automatic near_jumps();
      begin_program();
      mov_imm(3'd3, 16'h1111);
      // FFF3 skips to FFFA
      short_jmp(8'h05);
      // FFF5 only reached by the backward jump
      mov_imm(3'd5, 16'hDEAD);
      nop_instr();
      nop_instr();
      // FFFA forward to 1000F
      short_jmp(8'h13);
      origin(32'h0001_000F);
      mov_imm(3'd4, 16'h2222);
      // 10012 back to FFF5
      near_jmp(16'hFFE0);
      release_reset();
      collect_retires(N_NEAR);
      check_registers();
   endtask

   task automatic segment_change();
      addr_t want;
      logic  found;
      begin_program();
      nop_instr();
      far_jmp(16'h0123, 16'h2345);
      origin(32'h0000_0123);
      mov_imm(3'd6, 16'h5A5A);
      self_loop();
      release_reset();
      collect_retires(N_FAR);
      // Line-aligned new segment base plus offset
      want  = ({16'h2345, 16'h0} + 32'h0000_0123) & 32'hFFFF_FFF0;
      found = 1'b0;
      for (int i = 0; i < i_imem.accept_log.size(); i++) begin
         if (!found && i_imem.accept_log[i][31:16] == 16'h2345) begin
            found = 1'b1;
            compare_field("imem_address", i_imem.accept_log[i], want);
         end
      end
      if (!found) begin
         $display("No request was issued in the new code segment");
         errors++;
      end
   endtask

   task automatic illegal_opcodes();
      begin_program();
      code_byte(8'h0F);
      code_byte(8'h00);
      code_byte(8'hFF);
      nop_instr();
      code_byte(8'hC3);
      mov_imm(3'd7, 16'h7777);
      // Just below the MOV range
      code_byte(8'hB7);
      code_byte(8'h62);
      self_loop();
      release_reset();
      collect_retires(N_ILLEGAL);
      check_registers();
   endtask

   // Nine-instruction loop run many times under memory jitter
   task automatic random_timing();
      begin_program();
      mov_imm(3'd0, 16'h0A0A);
      nop_instr();
      short_jmp(8'h03);
      mov_imm(3'd1, 16'hDEAD);
      mov_imm(3'd1, 16'h1B1B);
      // FFFC forward to 10047
      near_jmp(16'h0048);
      origin(32'h0001_0047);
      mov_imm(3'd2, 16'h2C2C);
      code_byte(8'h62);
      nop_instr();
      // 1004C back to FFF0
      near_jmp(16'hFFA1);
      release_reset();
      collect_retires(N_RANDOM);
      check_registers();
   endtask

   initial begin
      #(WATCHDOG_CYCLES * 10);
      $display("Timeout after %0d cycles, retirements stopped arriving", WATCHDOG_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      clk     = 1'b0;
      rst     = 1'b1;
      reg_sel = 3'd0;
      wp      = 12'h0;
      errors  = 0;
      checks  = 0;
      first_requests();
      straight_line();
      near_jumps();
      segment_change();
      illegal_opcodes();
      random_timing();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- bench/tb_imem.sv
// ====================
// Instruction memory model for the fetch testbench
// 4 KB byte image, in-order line responses, random latency and ready gaps
// ====================
`timescale 1ns/1ps

module tb_imem (
   input  logic             clk,
   input  logic             rst,
   input  logic             imem_valid,
   input  fetch_pkg::addr_t imem_address,
   output logic             imem_ready,
   output logic             imem_rvalid,
   output fetch_pkg::line_t imem_rdata
);
   import fetch_pkg::*;

   // Loaded by the testbench while reset is held
   logic [7:0]  image [4096];
   addr_t       accept_log [$];
   addr_t       addr_q [$];
   int          due_q [$];
   logic [31:0] rng;
   logic        rst_q;
   int          cyc;
   int          last_due;
   int          due;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Image wraps every 4 KB of linear address
   function automatic line_t read_line(input addr_t a);
      line_t l;
      for (int i = 0; i < LINE_BYTES; i++)
         l[8*i +: 8] = image[{a[11:4], i[3:0]}];
      return l;
   endfunction

   initial begin
      rng         = 32'hc3a7345b;
      cyc         = 0;
      last_due    = 0;
      imem_ready  = 1'b0;
      imem_rvalid = 1'b0;
      imem_rdata  = '0;
   end

   // Reset as the DUT saw it at the last rising edge
   always @(posedge clk)
      rst_q <= rst;

   always @(negedge clk) begin
      cyc         = cyc + 1;
      imem_rvalid = 1'b0;
      if (rst_q) begin
         addr_q.delete();
         due_q.delete();
         accept_log.delete();
         imem_ready = 1'b0;
         last_due   = cyc;
      end else begin
         // Oldest request answers first
         if (due_q.size() > 0 && due_q[0] <= cyc) begin
            imem_rvalid = 1'b1;
            imem_rdata  = read_line(addr_q.pop_front());
            due         = due_q.pop_front();
         end
         rng = xorshift(rng);
         // Roughly one cycle in four without ready
         imem_ready = (rng[1:0] != 2'b00);
         if (imem_valid && imem_ready) begin
            rng = xorshift(rng);
            // Latency of one to four cycles and never ahead of an older request
            due = cyc + 1 + int'(rng[1:0]);
            if (due <= last_due)
               due = last_due + 1;
            last_due = due;
            addr_q.push_back(imem_address);
            due_q.push_back(due);
            accept_log.push_back(imem_address);
         end
      end
   end

endmodule

//--- hw/fetch_top.sv
// ====================
// Front end top level, fetch through retirement
// Memory request and response ports face the instruction memory
// ====================
`timescale 1ns/1ps

module fetch_top (
   input  logic               clk,
   input  logic               rst,
   input  logic               imem_ready,
   input  logic               imem_rvalid,
   input  fetch_pkg::line_t   imem_rdata,
   input  logic [2:0]         reg_sel,
   output logic               imem_valid,
   output fetch_pkg::addr_t   imem_address,
   output logic               retire,
   output fetch_pkg::retire_t retire_info,
   output logic [15:0]        reg_value
);
   import fetch_pkg::*;

   logic      fetch_enable;
   logic      redirect;
   redirect_t redir;
   window_t   window;
   byte_cnt_t avail;
   logic      consume;
   logic [2:0] consume_len;
   logic      dec_valid;
   decoded_t  dec;
   logic      ex_valid;
   retire_t   ex_rec;

   address_generation i_address_generation (
      .clk          (clk),
      .rst          (rst),
      .redirect     (redirect),
      .redir        (redir),
      .fetch_enable (fetch_enable),
      .imem_ready   (imem_ready),
      .imem_valid   (imem_valid),
      .imem_address (imem_address)
   );

   prefetch_queue i_prefetch_queue (
      .clk          (clk),
      .rst          (rst),
      .imem_ready   (imem_ready),
      .imem_rvalid  (imem_rvalid),
      .imem_rdata   (imem_rdata),
      .redirect     (redirect),
      .redir        (redir),
      .consume      (consume),
      .consume_len  (consume_len),
      .fetch_enable (fetch_enable),
      .window       (window),
      .avail        (avail)
   );

   instr_decode i_instr_decode (
      .clk         (clk),
      .rst         (rst),
      .window      (window),
      .avail       (avail),
      .redirect    (redirect),
      .consume     (consume),
      .consume_len (consume_len),
      .dec_valid   (dec_valid),
      .dec         (dec)
   );

   branch_execute i_branch_execute (
      .clk       (clk),
      .rst       (rst),
      .dec_valid (dec_valid),
      .dec       (dec),
      .redirect  (redirect),
      .redir     (redir),
      .ex_valid  (ex_valid),
      .ex_rec    (ex_rec)
   );

   retire_result i_retire_result (
      .clk         (clk),
      .rst         (rst),
      .ex_valid    (ex_valid),
      .ex_rec      (ex_rec),
      .reg_sel     (reg_sel),
      .retire      (retire),
      .retire_info (retire_info),
      .reg_value   (reg_value)
   );

endmodule

//--- hw/retire_result.sv
// ====================
// Register file write-back and retirement record
// ====================
`timescale 1ns/1ps

module retire_result (
   input  logic               clk,
   input  logic               rst,
   input  logic               ex_valid,
   input  fetch_pkg::retire_t ex_rec,
   input  logic [2:0]         reg_sel,
   output logic               retire,
   output fetch_pkg::retire_t retire_info,
   output logic [15:0]        reg_value
);
   import fetch_pkg::*;

   // Eight 16-bit general registers
   logic [15:0] regs [8];

   always_ff @(posedge clk) begin
      if (rst) begin
         retire <= 1'b0;
         for (int i = 0; i < 8; i++)
            regs[i] <= 16'h0;
      end else begin
         retire <= ex_valid;
         // Write lands on the same edge as retire
         if (ex_valid && (ex_rec.kind == K_MOV))
            regs[ex_rec.dest] <= ex_rec.wr_value;
      end
   end

   always_ff @(posedge clk) begin
      if (ex_valid)
         retire_info <= ex_rec;
   end

   // Debug read port
   assign reg_value = regs[reg_sel];

endmodule

//--- hw/branch_execute.sv
// ====================
// Architectural IP and CS, jump resolution and fetch redirect
// ====================
`timescale 1ns/1ps

module branch_execute (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  dec_valid,
   input  fetch_pkg::decoded_t   dec,
   output logic                  redirect,
   output fetch_pkg::redirect_t  redir,
   output logic                  ex_valid,
   output fetch_pkg::retire_t    ex_rec
);
   import fetch_pkg::*;

   offset_t ip;
   seg_t    cs;
   offset_t next_ip;
   offset_t near_target;
   logic    accept;
   logic    is_jump;

   // Instruction behind a jump is wrong-path during its redirect
   assign accept  = dec_valid && !redirect;
   assign is_jump = (dec.kind == K_JMP_NEAR) || (dec.kind == K_JMP_FAR);

   assign next_ip     = ip + offset_t'(dec.len);
   assign near_target = next_ip + dec.imm;

   always_ff @(posedge clk) begin
      if (rst) begin
         ip       <= RESET_OFFSET;
         cs       <= RESET_CS;
         ex_valid <= 1'b0;
         redirect <= 1'b0;
      end else begin
         ex_valid <= accept;
         redirect <= accept && is_jump;
         if (accept) begin
            case (dec.kind)
               K_JMP_NEAR: ip <= near_target;
               K_JMP_FAR: begin
                  ip <= {16'h0, dec.imm[15:0]};
                  cs <= dec.imm[31:16];
               end
               default: ip <= next_ip;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         ex_rec.cs       <= cs;
         ex_rec.offset   <= ip;
         ex_rec.opcode   <= dec.opcode;
         ex_rec.len      <= dec.len;
         ex_rec.kind     <= dec.kind;
         ex_rec.dest     <= dec.reg_idx;
         // Only MOV writes a register
         ex_rec.wr_value <= (dec.kind == K_MOV) ? dec.imm[15:0] : 16'h0;
         // Far target keeps the offset zero-extended
         redir.offset <= (dec.kind == K_JMP_FAR) ? {16'h0, dec.imm[15:0]} : near_target;
         redir.cs     <= (dec.kind == K_JMP_FAR) ? dec.imm[31:16] : cs;
      end
   end

endmodule

//--- hw/instr_decode.sv
// ====================
// Instruction length and kind decoder
// Consumes one whole instruction from the queue window per cycle
// ====================
`timescale 1ns/1ps

module instr_decode (
   input  logic                 clk,
   input  logic                 rst,
   input  fetch_pkg::window_t   window,
   input  fetch_pkg::byte_cnt_t avail,
   input  logic                 redirect,
   output logic                 consume,
   output logic [2:0]           consume_len,
   output logic                 dec_valid,
   output fetch_pkg::decoded_t  dec
);
   import fetch_pkg::*;

   logic [7:0]  opcode;
   instr_kind_e kind;
   logic [2:0]  len;
   logic [31:0] imm;

   assign opcode = window[7:0];

   always_comb begin
      kind = K_ILLEGAL;
      len  = 3'd1;
      imm  = 32'h0;
      if (opcode == OP_NOP) begin
         kind = K_NOP;
      end else if (opcode[7:3] == OP_MOV_BASE[7:3]) begin
         kind = K_MOV;
         len  = 3'd3;
         imm  = {16'h0, window[23:8]};
      end else if (opcode == OP_JMP8) begin
         kind = K_JMP_NEAR;
         len  = 3'd2;
         // Sign-extended rel8
         imm  = {{24{window[15]}}, window[15:8]};
      end else if (opcode == OP_JMP16) begin
         kind = K_JMP_NEAR;
         len  = 3'd3;
         imm  = {{16{window[23]}}, window[23:8]};
      end else if (opcode == OP_JMPF) begin
         kind = K_JMP_FAR;
         len  = 3'd5;
         // New CS lands in the upper half
         imm  = window[39:8];
      end
   end

   // Wait for the whole instruction, never during a flush
   assign consume     = !redirect && (avail >= len);
   assign consume_len = len;

   always_ff @(posedge clk) begin
      if (rst)
         dec_valid <= 1'b0;
      else
         dec_valid <= consume;
   end

   always_ff @(posedge clk) begin
      if (consume) begin
         dec.kind    <= kind;
         dec.opcode  <= opcode;
         dec.len     <= len;
         dec.reg_idx <= opcode[2:0];
         dec.imm     <= imm;
      end
   end

endmodule

//--- hw/prefetch_queue.sv
// ====================
// Two-line byte queue between instruction memory and decode
// Presents the next five bytes and tracks requests in flight
// ====================
`timescale 1ns/1ps

module prefetch_queue (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 imem_ready,
   input  logic                 imem_rvalid,
   input  fetch_pkg::line_t     imem_rdata,
   input  logic                 redirect,
   input  fetch_pkg::redirect_t redir,
   input  logic                 consume,
   input  logic [2:0]           consume_len,
   output logic                 fetch_enable,
   output fetch_pkg::window_t   window,
   output fetch_pkg::byte_cnt_t avail
);
   import fetch_pkg::*;

   // Circular byte store of two lines
   logic [7:0] store [LINE_BYTES*QUEUE_LINES];

   logic [4:0] head;
   logic [4:0] tail;
   logic [5:0] count;
   logic [2:0] outstanding;
   logic [2:0] drop_cnt;
   logic [3:0] skip;
   logic       run;
   logic [2:0] lines_held;
   logic       issue;
   logic       resp_drop;
   logic       line_take;
   logic [5:0] wr_len;
   logic [2:0] rd_len;

   // Partial line counts as a full one
   assign lines_held = 3'((count + LINE_BYTES - 1) / LINE_BYTES);

   // Held off for one cycle after reset
   assign fetch_enable = run && ((lines_held + outstanding) < QUEUE_LINES);

   assign issue     = fetch_enable && imem_ready;
   assign resp_drop = imem_rvalid && (drop_cnt != 3'd0);
   assign line_take = imem_rvalid && (drop_cnt == 3'd0) && !redirect;

   assign tail   = head + count[4:0];
   assign wr_len = line_take ? 6'(LINE_BYTES - skip) : 6'd0;
   assign rd_len = consume ? consume_len : 3'd0;

   always_ff @(posedge clk) begin
      if (rst) begin
         head        <= '0;
         count       <= '0;
         outstanding <= '0;
         drop_cnt    <= '0;
         skip        <= RESET_OFFSET[3:0];
         run         <= 1'b0;
      end else begin
         run <= 1'b1;
         if (redirect) begin
            // Everything in flight is now stale, including this cycle's request
            head        <= '0;
            count       <= '0;
            outstanding <= '0;
            drop_cnt    <= drop_cnt + outstanding + 3'(issue) - 3'(imem_rvalid);
            skip        <= redir.offset[3:0];
         end else begin
            head        <= head + 5'(rd_len);
            count       <= count + wr_len - 6'(rd_len);
            outstanding <= outstanding + 3'(issue) - 3'(line_take);
            drop_cnt    <= drop_cnt - 3'(resp_drop);
            // Skip applies to the first line only
            if (line_take)
               skip <= 4'h0;
         end
      end
   end

   // Leading bytes below the target offset never enter the store
   always_ff @(posedge clk) begin
      if (line_take) begin
         for (int i = 0; i < LINE_BYTES; i++) begin
            if (i >= skip)
               store[5'(tail + i - skip)] <= imem_rdata[8*i +: 8];
         end
      end
   end

   // Byte 0 of the window in the low bits
   always_comb begin
      for (int i = 0; i < 5; i++)
         window[8*i +: 8] = store[5'(head + i)];
   end

   assign avail = (count > 6'd5) ? 3'd5 : count[2:0];

endmodule

//--- hw/address_generation.sv
// ====================
// Line fetch address generator for the code segment
// Issues one 16-byte line request per valid/ready handshake
// ====================
`timescale 1ns/1ps

module address_generation (
   input  logic                clk,
   input  logic                rst,
   input  logic                redirect,
   input  fetch_pkg::redirect_t redir,
   input  logic                fetch_enable,
   input  logic                imem_ready,
   output logic                imem_valid,
   output fetch_pkg::addr_t    imem_address
);
   import fetch_pkg::*;

   // Offset of the line being requested, low bits may be nonzero
   offset_t fetch_offset;
   seg_t    cs_reg;
   addr_t   linear;
   logic    accepted;

   // Queue decides when there is room
   assign imem_valid = fetch_enable;
   assign accepted   = imem_valid && imem_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         fetch_offset <= RESET_OFFSET;
         cs_reg       <= RESET_CS;
      end else if (redirect) begin
         // Redirect wins over a same-cycle advance
         fetch_offset <= redir.offset;
         cs_reg       <= redir.cs;
      end else if (accepted) begin
         fetch_offset <= fetch_offset + offset_t'(LINE_BYTES);
      end
   end

   // Segment base is CS times 64K
   assign linear = {cs_reg, 16'h0000} + fetch_offset;

   // Always a whole line
   assign imem_address = {linear[31:4], 4'h0};

endmodule

//--- hw/fetch_pkg.sv
// ====================
// Shared types and constants for the instruction fetch front end
// Import inside a module body, use scoped names in port lists
// ====================
package fetch_pkg;

   // Meaningful widths
   typedef logic [31:0]  offset_t;
   typedef logic [15:0]  seg_t;
   typedef logic [31:0]  addr_t;
   typedef logic [127:0] line_t;
   typedef logic [39:0]  window_t;
   typedef logic [2:0]   byte_cnt_t;

   // Reset vector, real-mode style
   localparam seg_t    RESET_CS     = 16'hF000;
   localparam offset_t RESET_OFFSET = 32'h0000_FFF0;

   // Queue geometry
   localparam int LINE_BYTES  = 16;
   localparam int QUEUE_LINES = 2;

   // Opcodes
   localparam logic [7:0] OP_NOP      = 8'h90;
   localparam logic [7:0] OP_MOV_BASE = 8'hB8;
   localparam logic [7:0] OP_JMP8     = 8'hEB;
   localparam logic [7:0] OP_JMP16    = 8'hE9;
   localparam logic [7:0] OP_JMPF     = 8'hEA;

   typedef enum logic [2:0] {
      K_NOP,
      K_MOV,
      K_JMP_NEAR,
      K_JMP_FAR,
      K_ILLEGAL
   } instr_kind_e;

   // Immediate holds displacement, MOV value, or {new CS, far offset}
   typedef struct packed {
      instr_kind_e kind;
      logic [7:0]  opcode;
      logic [2:0]  len;
      logic [2:0]  reg_idx;
      logic [31:0] imm;
   } decoded_t;

   typedef struct packed {
      offset_t offset;
      seg_t    cs;
   } redirect_t;

   typedef struct packed {
      seg_t        cs;
      offset_t     offset;
      logic [7:0]  opcode;
      logic [2:0]  len;
      instr_kind_e kind;
      logic [2:0]  dest;
      logic [15:0] wr_value;
   } retire_t;

endpackage
